/* M68kDramController.f */
+incdir+include
hdl/sdramPkg.sv
hdl/sdramCmdIf.sv
hdl/countdownTimer.sv
hdl/dramSequencer.sv
hdl/sdramPins.sv
hdl/M68kDramController.sv
test/sdramModel.sv
test/tbM68kDramController.sv

/* hdl/M68kDramController.sv */
`timescale 1ns/1ps
`default_nettype none

module M68kDramController import sdramPkg::*; (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire cpuAddr_t Address,
	input wire dramData_t DataIn,
	input wire logic UDS_L,
	input wire logic LDS_L,
	input wire logic DramSelect_L,
	input wire logic WE_L,
	input wire logic AS_L,
	output dramData_t DataOut,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output rowAddr_t SDram_Addr,
	output bankAddr_t SDram_BA,
	inout wire dramData_t SDram_DQ,
	output logic Dtack_L,
	output logic ResetOut_L
);

	logic phaseLoad, phaseStep, phaseDone;
	logic refreshLoad, refreshStep, refreshDone;
	logic loopLoad, loopStep, loopDone;
	timerCount_t phaseValue, refreshValue, loopValue;

	sdramCmdIf cmdBus ();

	dramSequencer dramSeq (
		.Clock, .Reset_L, .address(Address), .dataIn(DataIn),
		.uds(UDS_L), .lds(LDS_L), .dramSelect(DramSelect_L),
		.writeEnable(WE_L), .addrStrobe(AS_L),
		.phaseLoad, .phaseValue, .phaseStep,
		.refreshLoad, .refreshValue, .refreshStep,
		.loopLoad, .loopValue, .loopStep,
		.phaseDone, .refreshDone, .loopDone, .cmdIf(cmdBus.sequencer)
	);

	countdownTimer phaseTimer (.Clock, .Reset_L, .load(phaseLoad),
		.loadValue(phaseValue), .step(phaseStep), .done(phaseDone));
	countdownTimer refreshTimer (.Clock, .Reset_L, .load(refreshLoad),
		.loadValue(refreshValue), .step(refreshStep), .done(refreshDone));
	countdownTimer refreshLoop (.Clock, .Reset_L, .load(loopLoad),
		.loadValue(loopValue), .step(loopStep), .done(loopDone));

	sdramPins pinDriver (
		.Clock, .Reset_L, .cmdIf(cmdBus.pins),
		.sdramCke(SDram_CKE_H), .sdramCs(SDram_CS_L), .sdramRas(SDram_RAS_L),
		.sdramCas(SDram_CAS_L), .sdramWe(SDram_WE_L),
		.sdramAddr(SDram_Addr), .sdramBank(SDram_BA), .sdramDq(SDram_DQ),
		.dataOut(DataOut), .dtack(Dtack_L), .resetOut(ResetOut_L)
	);

endmodule

`default_nettype wire

/* hdl/countdownTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module countdownTimer import sdramPkg::*; (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire logic load, // takes loadValue on the next edge
	input wire timerCount_t loadValue,
	input wire logic step, // count enable
	output logic done // high while the count sits at zero
);

	timerCount_t count;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			count <= '0; // starts out done
		end else if (load) begin
			count <= loadValue; // load wins over step
		end else if (step && (count != '0)) begin
			count <= count - 1'b1; // stops at zero
		end
	end

	assign done = (count == '0);

endmodule

`default_nettype wire

/* hdl/dramSequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

module dramSequencer import sdramPkg::*; (
	input wire logic Clock,
	input wire logic Reset_L,
	input wire cpuAddr_t address,
	input wire dramData_t dataIn,
	input wire logic uds, // active low strobes from the CPU
	input wire logic lds,
	input wire logic dramSelect,
	input wire logic writeEnable,
	input wire logic addrStrobe,
	output logic phaseLoad, // power-up and CAS wait timer
	output timerCount_t phaseValue,
	output logic phaseStep,
	output logic refreshLoad, // refresh interval timer
	output timerCount_t refreshValue,
	output logic refreshStep,
	output logic loopLoad, // init refresh counter
	output timerCount_t loopValue,
	output logic loopStep,
	input wire logic phaseDone,
	input wire logic refreshDone,
	input wire logic loopDone,
	sdramCmdIf.sequencer cmdIf
);

	localparam rowAddr_t allBanksA10 = 13'h0400; // A10 alone, precharge all

	ctrlState_t state, stateNext;
	logic [1:0] nopCount, nopCountNext; // NOPs left after an auto refresh
	rowAddr_t colAddr; // column with auto-precharge
	logic strobeLow; // either data strobe asserted

	assign colAddr = {2'b00, 1'b1, address[10:1]};
	assign strobeLow = !uds || !lds;

	assign phaseStep = (state == powerWait) || (state == casWait); // counts only while waited on
	assign refreshStep = 1'b1; // interval runs free, reloaded per refresh

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= initLoad;
			nopCount <= '0;
		end else begin
			state <= stateNext;
			nopCount <= nopCountNext;
		end
	end

	//////////////////////////////////////////////////
	// next state and pin decisions
	//////////////////////////////////////////////////

	always_comb begin
		stateNext = state;
		nopCountNext = nopCount;
		cmdIf.cmd = nop;
		cmdIf.addr = '0;
		cmdIf.bank = '0;
		cmdIf.writeData = '0;
		cmdIf.driveDq = 1'b0; // DQ tristated unless writing
		cmdIf.latchRead = 1'b0;
		cmdIf.cpuDtack = 1'b1;
		cmdIf.cpuReset = 1'b0; // CPU held in reset until idle
		phaseLoad = 1'b0;
		phaseValue = '0;
		refreshLoad = 1'b0;
		refreshValue = '0;
		loopLoad = 1'b0;
		loopValue = '0;
		loopStep = 1'b0;
		case (state)
			initLoad: begin
				cmdIf.cmd = powerUp;
				phaseLoad = 1'b1;
				phaseValue = timerCount_t'(`SDRAM_POWERUP_CYCLES);
				stateNext = powerWait;
			end
			powerWait: begin
				cmdIf.cmd = powerUp; // CKE and CS low for the whole wait
				if (phaseDone) stateNext = initNop;
			end
			initNop: stateNext = initPrecharge; // first NOP with CKE high
			initPrecharge: begin
				cmdIf.cmd = precharge;
				cmdIf.addr = allBanksA10;
				stateNext = initPrechargeNop;
			end
			initPrechargeNop: begin
				loopLoad = 1'b1;
				loopValue = timerCount_t'(`SDRAM_INIT_REFRESHES);
				stateNext = initRefresh;
			end
			initRefresh: begin
				cmdIf.cmd = autoRefresh;
				loopStep = 1'b1; // one refresh counted off
				nopCountNext = 2'(`SDRAM_REFRESH_NOPS - 1);
				stateNext = initRefreshNops;
			end
			initRefreshNops: begin
				nopCountNext = nopCount - 2'd1;
				if (nopCount == '0) stateNext = loopDone ? modeLoad : initRefresh;
			end
			modeLoad: begin
				cmdIf.cmd = modeSet;
				cmdIf.addr = `SDRAM_MODE_WORD; // bank bits stay zero
				stateNext = modeNop;
			end
			modeNop: begin
				refreshLoad = 1'b1; // first interval starts here
				refreshValue = timerCount_t'(`SDRAM_REFRESH_CYCLES);
				stateNext = idle;
			end
			idle: begin
				cmdIf.cpuReset = 1'b1;
				if (refreshDone) begin // refresh beats a waiting CPU cycle
					cmdIf.cmd = precharge;
					cmdIf.addr = allBanksA10;
					refreshLoad = 1'b1;
					refreshValue = timerCount_t'(`SDRAM_REFRESH_CYCLES);
					stateNext = refreshNop;
				end else if (!addrStrobe && !dramSelect) begin
					cmdIf.cmd = activate;
					cmdIf.addr = address[23:11]; // row
					cmdIf.bank = address[25:24];
					stateNext = writeEnable ? readCmd : writeWait;
				end
			end
			refreshNop: begin
				cmdIf.cpuReset = 1'b1;
				stateNext = refreshCmd;
			end
			refreshCmd: begin
				cmdIf.cpuReset = 1'b1;
				cmdIf.cmd = autoRefresh;
				nopCountNext = 2'(`SDRAM_REFRESH_NOPS - 1);
				stateNext = refreshNops;
			end
			refreshNops: begin
				cmdIf.cpuReset = 1'b1;
				nopCountNext = nopCount - 2'd1;
				if (nopCount == '0) stateNext = idle;
			end
			writeWait: begin
				cmdIf.cpuReset = 1'b1;
				if (strobeLow) begin // data on the bus now
					cmdIf.cmd = write;
					cmdIf.addr = colAddr;
					cmdIf.bank = address[25:24];
					cmdIf.writeData = dataIn;
					cmdIf.driveDq = 1'b1;
					cmdIf.cpuDtack = 1'b0;
					stateNext = writeHold;
				end
			end
			writeHold: begin
				cmdIf.cpuReset = 1'b1;
				cmdIf.writeData = dataIn; // second cycle of DQ drive
				cmdIf.driveDq = 1'b1;
				cmdIf.cpuDtack = 1'b0;
				stateNext = dataPhase;
			end
			readCmd: begin
				cmdIf.cpuReset = 1'b1;
				cmdIf.cmd = read;
				cmdIf.addr = colAddr;
				cmdIf.bank = address[25:24];
				phaseLoad = 1'b1;
				phaseValue = timerCount_t'(`SDRAM_CAS_LATENCY - 1); // pins add one cycle
				stateNext = casWait;
			end
			casWait: begin
				cmdIf.cpuReset = 1'b1;
				if (phaseDone) begin
					cmdIf.latchRead = 1'b1; // DQ caught on the next falling edge
					stateNext = dataPhase;
				end
			end
			dataPhase: begin
				cmdIf.cpuReset = 1'b1;
				if (strobeLow) cmdIf.cpuDtack = 1'b0; // hold until both strobes rise
				else stateNext = idle;
			end
			default: stateNext = initLoad;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/sdramCmdIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface sdramCmdIf import sdramPkg::*; ();

	sdramCmd_t cmd; // command for the next pin cycle
	rowAddr_t addr; // row, column or mode word
	bankAddr_t bank;
	dramData_t writeData; // word for DQ during a write
	logic driveDq; // enables the DQ drivers
	logic latchRead; // one-cycle pulse, catch DQ on the next falling edge
	logic cpuDtack; // active low
	logic cpuReset; // active low

	modport sequencer (
		output cmd, addr, bank, writeData, driveDq, latchRead, cpuDtack, cpuReset
	);

	modport pins (
		input cmd, addr, bank, writeData, driveDq, latchRead, cpuDtack, cpuReset
	);

endinterface

`default_nettype wire

/* hdl/sdramPins.sv */
`timescale 1ns/1ps
`default_nettype none

module sdramPins import sdramPkg::*; (
	input wire logic Clock,
	input wire logic Reset_L,
	sdramCmdIf.pins cmdIf,
	output logic sdramCke,
	output logic sdramCs,
	output logic sdramRas,
	output logic sdramCas,
	output logic sdramWe,
	output rowAddr_t sdramAddr,
	output bankAddr_t sdramBank,
	inout wire dramData_t sdramDq,
	output dramData_t dataOut,
	output logic dtack,
	output logic resetOut
);

	sdramCmd_t cmdQ;
	dramData_t writeDataQ;
	logic driveDqQ;
	logic latchQ;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			cmdQ <= powerUp; // CKE and CS low from reset on
			driveDqQ <= 1'b0;
			latchQ <= 1'b0;
			dtack <= 1'b1;
			resetOut <= 1'b0;
		end else begin
			cmdQ <= cmdIf.cmd;
			driveDqQ <= cmdIf.driveDq;
			latchQ <= cmdIf.latchRead;
			dtack <= cmdIf.cpuDtack;
			resetOut <= cmdIf.cpuReset;
		end
	end

	always_ff @(posedge Clock) begin
		sdramAddr <= cmdIf.addr;
		sdramBank <= cmdIf.bank;
		writeDataQ <= cmdIf.writeData;
	end

	assign {sdramCke, sdramCs, sdramRas, sdramCas, sdramWe} = cmdQ;
	assign sdramDq = driveDqQ ? writeDataQ : 'z; // SDRAM owns DQ otherwise

	// mid-cycle sample, inside the read data window
	always_ff @(negedge Clock) begin
		if (latchQ) dataOut <= sdramDq;
	end

endmodule

`default_nettype wire

/* hdl/sdramPkg.sv */
`default_nettype none
`include "sdram_defines.svh"

package sdramPkg;

	typedef logic [31:0] cpuAddr_t; // 68000 address bus
	typedef logic [15:0] dramData_t; // one SDRAM word
	typedef logic [12:0] rowAddr_t; // row, or column with A10 on the same pins
	typedef logic [1:0] bankAddr_t; // one of four banks
	typedef logic [`SDRAM_TIMER_WIDTH-1:0] timerCount_t;

	// bit order is CKE, CS_L, RAS_L, CAS_L, WE_L
	typedef enum logic [4:0] {
		powerUp = 5'b00000, // CKE and CS held low
		nop = 5'b10111,
		precharge = 5'b10010, // all banks when A10 is high
		autoRefresh = 5'b10001,
		modeSet = 5'b10000,
		activate = 5'b10011,
		read = 5'b10101, // auto-precharge when A10 is high
		write = 5'b10100
	} sdramCmd_t;

	typedef enum logic [4:0] {
		initLoad, powerWait, initNop, initPrecharge, initPrechargeNop, // power-up
		initRefresh, initRefreshNops, modeLoad, modeNop, // init refreshes and mode
		idle, refreshNop, refreshCmd, refreshNops, // periodic refresh
		writeWait, writeHold, readCmd, casWait, dataPhase // CPU access
	} ctrlState_t;

endpackage

`default_nettype wire

/* include/sdram_defines.svh */
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

//////////////////////////////////////////////////
// SDRAM timing, all counts in 50 MHz clocks
//////////////////////////////////////////////////

`define SDRAM_POWERUP_CYCLES 5000 // 100 us power-up wait
`define SDRAM_REFRESH_CYCLES 375 // 7.5 us between auto refreshes
`define SDRAM_INIT_REFRESHES 8 // auto refreshes during init
`define SDRAM_REFRESH_NOPS 3 // NOPs after each auto refresh (tRC)
`define SDRAM_CAS_LATENCY 2 // must agree with the mode word

//////////////////////////////////////////////////
// mode register and counter geometry
//////////////////////////////////////////////////

// burst length 1, sequential, CL=2, single-location write
`define SDRAM_MODE_WORD 13'h220
`define SDRAM_TIMER_WIDTH 16 // wide enough for the power-up count

`endif

/* run.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the failure line
rm -f sim.log
verilator --binary --timing -f M68kDramController.f --top-module tbM68kDramController \
	-o tbM68kDramController \
	&& ./obj_dir/tbM68kDramController > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAILED"; exit 1; } || { echo "PASSED"; exit 0; }

/* test/m68k_dram_tests.txt */
// op (0 write, 1 read, 2 idle, f end), CPU byte address, data
// data is the word written, the word expected back, or the idle length in cycles
0 00000000 1234
1 00000000 1234
0 01000ffe abcd
0 02fff800 5a5a
0 03abc456 0f0f
1 01000ffe abcd
1 02fff800 5a5a
1 03abc456 0f0f
2 00000000 00000384
0 00000002 beef
1 00000002 beef
1 00000000 1234
2 00000000 000001a0
0 00fffffe 8001
1 00fffffe 8001
0 00000000 4321
1 00000000 4321
f 00000000 00000000

/* test/sdramModel.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

module sdramModel import sdramPkg::*; (
	input wire logic Clock,
	input wire logic cke,
	input wire logic cs,
	input wire logic ras,
	input wire logic cas,
	input wire logic we,
	input wire rowAddr_t addr,
	input wire bankAddr_t bank,
	inout wire dramData_t dq,
	input wire cpuAddr_t cpuAddress, // address of the CPU cycle in flight
	output logic initDone, // mode register loaded
	output int errorCount
);

	localparam int refreshLimit = `SDRAM_REFRESH_CYCLES + 10; // longest gap between refreshes

	dramData_t mem [logic [24:0]]; // keyed by bank, row, column
	rowAddr_t openRow [0:3];
	logic prechargeAll; // all banks closed since the last activate
	int initRefreshes;
	int sinceRefresh; // edges since the last auto refresh
	logic refreshLate;
	logic [1:0] readCount; // CAS latency pipeline
	dramData_t readWord;

	initial begin
		initDone = 1'b0;
		errorCount = 0;
		prechargeAll = 1'b0;
		initRefreshes = 0;
		sinceRefresh = 0;
		refreshLate = 1'b0;
		readCount = '0;
		readWord = '0;
	end

	assign dq = (readCount == 2'd1) ? readWord : 'z; // one word, CL cycles after the read

	//////////////////////////////////////////////////
	// command decode on the rising edge
	//////////////////////////////////////////////////

	always @(posedge Clock) begin
		sdramCmd_t cmd;
		logic [24:0] key;
		cmd = sdramCmd_t'({cke, cs, ras, cas, we});
		key = {bank, openRow[bank], addr[9:0]};
		if (readCount != 2'd0) readCount <= readCount - 2'd1;
		if (initDone) begin
			if (cmd == autoRefresh) sinceRefresh <= 0;
			else sinceRefresh <= sinceRefresh + 1;
			if (sinceRefresh >= refreshLimit && !refreshLate) begin
				$display("no auto refresh within %0d cycles at %0t", refreshLimit, $time);
				errorCount = errorCount + 1;
				refreshLate <= 1'b1; // reported once
			end
		end
		case (cmd)
			precharge: if (addr[10]) prechargeAll <= 1'b1;
			autoRefresh: begin
				if (!prechargeAll) begin
					$display("auto refresh without precharge-all at %0t", $time);
					errorCount = errorCount + 1;
				end
				if (!initDone) initRefreshes <= initRefreshes + 1;
			end
			modeSet: begin
				if (!prechargeAll || initRefreshes != `SDRAM_INIT_REFRESHES) begin
					$display("mode register load out of order, %0d refreshes", initRefreshes);
					errorCount = errorCount + 1;
				end
				if (addr != `SDRAM_MODE_WORD) begin
					$display("mismatch at %0t: mode word %h", $time, addr);
					errorCount = errorCount + 1;
				end
				initDone <= 1'b1;
				sinceRefresh <= 0;
			end
			activate: begin
				if (!initDone) begin
					$display("activate before the mode register load at %0t", $time);
					errorCount = errorCount + 1;
				end
				if (addr != cpuAddress[23:11] || bank != cpuAddress[25:24]) begin
					$display("mismatch at %0t: activate row %h bank %0d for address %h",
						$time, addr, bank, cpuAddress);
					errorCount = errorCount + 1;
				end
				openRow[bank] <= addr;
				prechargeAll <= 1'b0; // a bank is open again
			end
			read, write: begin
				if (addr != {3'b001, cpuAddress[10:1]} || bank != cpuAddress[25:24]) begin
					$display("mismatch at %0t: column %h bank %0d for address %h",
						$time, addr, bank, cpuAddress);
					errorCount = errorCount + 1;
				end
				if (cmd == write) begin
					mem[key] = dq;
				end else begin
					// unwritten words read back an address pattern
					readWord <= mem.exists(key) ? mem[key] : (key[15:0] ^ {6'b0, key[24:15]});
					readCount <= 2'(`SDRAM_CAS_LATENCY);
				end
			end
			default: ; // nop and powerUp
		endcase
	end

endmodule

`default_nettype wire

/* test/tbM68kDramController.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sdram_defines.svh"

module tbM68kDramController import sdramPkg::*; ();

	localparam int maxOps = 64; // rows in the stimulus table
	localparam int dtackWait = 40; // covers a refresh in front of the access
	localparam int releaseWait = 4; // cycles for Dtack_L to rise again
	localparam int foreignCycles = 6; // long enough for a read to reach Dtack_L

	logic Clock;
	logic Reset_L;
	cpuAddr_t Address;
	dramData_t DataIn;
	logic UDS_L, LDS_L, DramSelect_L, WE_L, AS_L;
	dramData_t DataOut;
	logic SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L;
	rowAddr_t SDram_Addr;
	bankAddr_t SDram_BA;
	wire dramData_t SDram_DQ;
	logic Dtack_L, ResetOut_L;

	logic [31:0] testWords [0:3*maxOps-1]; // op, address, data per row
	logic [31:0] lfsrState;
	int errorCount, modelErrors, opCount, cycleCount, timeoutLimit;
	logic initDone, resetOutSeen, selectWasHigh;

	M68kDramController i_M68kDramController (
		.Clock, .Reset_L, .Address, .DataIn, .UDS_L, .LDS_L, .DramSelect_L, .WE_L, .AS_L,
		.DataOut, .SDram_CKE_H, .SDram_CS_L, .SDram_RAS_L, .SDram_CAS_L, .SDram_WE_L,
		.SDram_Addr, .SDram_BA, .SDram_DQ, .Dtack_L, .ResetOut_L
	);

	sdramModel sdram (
		.Clock, .cke(SDram_CKE_H), .cs(SDram_CS_L), .ras(SDram_RAS_L), .cas(SDram_CAS_L),
		.we(SDram_WE_L), .addr(SDram_Addr), .bank(SDram_BA), .dq(SDram_DQ),
		.cpuAddress(Address), .initDone, .errorCount(modelErrors)
	);

	initial Clock = 1'b0;
	always #5 Clock = ~Clock; // 100 MHz sim clock, 10 ns period

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount >= timeoutLimit) begin
			$display("timeout after %0d cycles, the run did not finish", cycleCount);
			$display("Done: errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// monitors on the falling edge
	//////////////////////////////////////////////////

	always @(negedge Clock) begin
		if (ResetOut_L === 1'b1 && !initDone) begin
			$display("ResetOut_L rose before the mode register load at %0t", $time);
			errorCount++;
		end
		if (resetOutSeen && ResetOut_L !== 1'b1) begin
			$display("ResetOut_L fell again at %0t", $time);
			errorCount++;
		end
		if (ResetOut_L === 1'b1) resetOutSeen = 1'b1;
		if (Dtack_L === 1'b0 && selectWasHigh) begin // Dtack_L lags the strobes by one cycle
			$display("Dtack_L low with AS_L or DramSelect_L high at %0t", $time);
			errorCount++;
		end
		selectWasHigh = AS_L || DramSelect_L;
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // taps 32 22 2 1
	endfunction

	function automatic int randomBits(input int count);
		int value;
		value = 0;
		for (int b = 0; b < count; b++) begin
			lfsrState = lfsrNext(lfsrState); // one step per bit
			value = (value << 1) | int'(lfsrState[0]);
		end
		return value;
	endfunction

	task automatic idleFor(input int cycles);
		repeat (cycles) @(posedge Clock);
	endtask

	// a bus cycle the controller must ignore, AS_L or DramSelect_L stays high
	task automatic otherDeviceCycle(input int cycles);
		logic selectHigh;
		selectHigh = (randomBits(1) != 0);
		@(posedge Clock);
		AS_L <= !selectHigh;
		DramSelect_L <= selectHigh;
		WE_L <= (randomBits(1) != 0);
		UDS_L <= 1'b0;
		LDS_L <= 1'b0;
		repeat (cycles) @(negedge Clock); // the monitor flags any Dtack_L
		@(posedge Clock);
		AS_L <= 1'b1;
		DramSelect_L <= 1'b1;
		UDS_L <= 1'b1;
		LDS_L <= 1'b1;
		WE_L <= 1'b1;
	endtask

	// one CPU bus cycle, data is the write word or the expected read word
	task automatic accessWord(input logic isRead, input cpuAddr_t addr, input dramData_t data);
		int waitCount;
		int holdCycles;
		int firstStrobe;
		@(posedge Clock);
		Address <= addr;
		if (!isRead) DataIn <= data;
		WE_L <= isRead;
		AS_L <= 1'b0;
		DramSelect_L <= 1'b0;
		UDS_L <= 1'b0;
		LDS_L <= 1'b0;
		waitCount = 0;
		@(negedge Clock);
		while (Dtack_L !== 1'b0 && waitCount < dtackWait) begin
			@(negedge Clock);
			waitCount++;
		end
		if (Dtack_L !== 1'b0) begin
			$display("no Dtack_L for the access to %h at %0t", addr, $time);
			errorCount++;
		end else if (isRead && DataOut !== data) begin
			$display("mismatch at %0t: read %h returned %h, expected %h",
				$time, addr, DataOut, data);
			errorCount++;
		end
		firstStrobe = randomBits(1); // which strobe the CPU drops first
		@(posedge Clock);
		if (firstStrobe != 0) UDS_L <= 1'b1;
		else LDS_L <= 1'b1;
		holdCycles = 1 + randomBits(1); // the other strobe stays low a little longer
		repeat (holdCycles) begin
			@(negedge Clock);
			if (Dtack_L !== 1'b0) begin
				$display("Dtack_L rose while a data strobe was still low at %0t", $time);
				errorCount++;
			end
		end
		@(posedge Clock);
		AS_L <= 1'b1;
		DramSelect_L <= 1'b1;
		UDS_L <= 1'b1;
		LDS_L <= 1'b1;
		WE_L <= 1'b1;
		waitCount = 0;
		@(negedge Clock);
		while (Dtack_L !== 1'b1 && waitCount < releaseWait) begin
			@(negedge Clock);
			waitCount++;
		end
		if (Dtack_L !== 1'b1) begin
			$display("Dtack_L stayed low after the strobes were released at %0t", $time);
			errorCount++;
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		Reset_L = 1'b0;
		Address = '0;
		DataIn = '0;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		DramSelect_L = 1'b1;
		WE_L = 1'b1;
		AS_L = 1'b1;
		errorCount = 0;
		cycleCount = 0;
		resetOutSeen = 1'b0;
		selectWasHigh = 1'b1;
		lfsrState = 32'h1598_22bf;
		$readmemh("test/m68k_dram_tests.txt", testWords);
		opCount = 0;
		while (opCount < maxOps && testWords[3*opCount] !== 32'hf) opCount++; // f ends the list
		timeoutLimit = `SDRAM_POWERUP_CYCLES + opCount * (`SDRAM_REFRESH_CYCLES + 20);
		repeat (5) @(posedge Clock);
		Reset_L <= 1'b1;
		while (ResetOut_L !== 1'b1) @(negedge Clock); // init done
		for (int i = 0; i < opCount; i++) begin
			idleFor(randomBits(3));
			if (testWords[3*i] == 32'h0 || testWords[3*i] == 32'h1) begin
				otherDeviceCycle(foreignCycles); // not for the SDRAM
			end
			case (testWords[3*i])
				32'h0: accessWord(1'b0, testWords[3*i+1], testWords[3*i+2][15:0]);
				32'h1: accessWord(1'b1, testWords[3*i+1], testWords[3*i+2][15:0]);
				32'h2: idleFor(int'(testWords[3*i+2]));
				default: begin
					$display("unknown operation %h in row %0d of the test file", testWords[3*i], i);
					errorCount++;
				end
			endcase
		end
		idleFor(4);
		$display("%0d operations, %0d testbench errors, %0d SDRAM model errors",
			opCount, errorCount, modelErrors);
		if (errorCount == 0 && modelErrors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
